//--- common/if1_pkg.sv
package if1_pkg;

    // andi r0, r0, 0
    localparam logic [31:0] inst_nop = 32'h0340_0000;

    // boot address, also shown by an empty stage
    localparam logic [31:0] pc_reset = 32'h1c00_0000;

    // one aligned fetch pair on its way to the decoder
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc_next;
        logic [31:0] inst0;
        logic [31:0] inst1;
        logic [31:0] badv;
        logic [6:0]  excp_code;
        logic [1:0]  excp_flag;
    } fetch_pkt_t;

    // contents of a cleared stage or skid register
    localparam fetch_pkt_t pkt_empty = '{
        pc:        pc_reset,
        pc_next:   pc_reset,
        inst0:     inst_nop,
        inst1:     inst_nop,
        badv:      32'h0,
        excp_code: 7'h0,
        excp_flag: 2'b00
    };

    // serialization controller states
    typedef enum logic [2:0] {
        ser_idle            = 3'd0,
        ser_wait_ex_ibar    = 3'd1,
        ser_wait_ex_csr     = 3'd2,
        ser_wait_ex_tlb     = 3'd3,
        ser_wait_cache_idle = 3'd4,
        ser_wait_csr_done   = 3'd5,
        ser_wait_tlb_done   = 3'd6
    } ser_state_t;

endpackage

//--- if1/if1_align.sv
`timescale 1ns/1ps

module if1_align import if1_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic        serializing,
    input  logic        icache_rvalid,
    input  logic [31:0] pc_out,
    input  logic [31:0] pc_next,
    input  logic [31:0] inst0,
    input  logic [31:0] inst1,
    input  logic [31:0] badv,
    input  logic [6:0]  excp_code,
    input  logic [1:0]  excp_flag,
    input  logic [1:0]  priv_flag,
    output logic        icache_ready,
    input  logic        queue_allowin,
    output logic        stage_valid,
    output fetch_pkt_t  stage_pkt
);

    logic       started;
    logic       skid_valid;
    fetch_pkt_t skid_pkt;
    fetch_pkt_t in_pkt;
    logic       in_take;
    logic       stage_free;

    // align the pair to the fetch pc
    always_comb begin
        in_pkt.pc        = pc_out;
        in_pkt.pc_next   = pc_next;
        in_pkt.inst0     = pc_out[2] ? inst1 : inst0;
        in_pkt.inst1     = pc_out[2] ? inst_nop : inst1;
        in_pkt.badv      = badv;
        in_pkt.excp_code = excp_code;
        // privileged op drops the fetch exception
        in_pkt.excp_flag = priv_flag[0] ? 2'b00 : excp_flag;
    end

    // stage can load this cycle if empty or draining into the queue
    assign stage_free   = !stage_valid || queue_allowin;
    assign in_take      = icache_rvalid && !serializing;
    assign icache_ready = started && !skid_valid && queue_allowin && !serializing;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            started     <= 1'b0;
            stage_valid <= 1'b0;
            skid_valid  <= 1'b0;
        end else begin
            started <= 1'b1;
            if (flush || serializing) begin
                stage_valid <= 1'b0;
                skid_valid  <= 1'b0;
            end else if (skid_valid && stage_free) begin
                // skid entry is older, it goes first
                stage_valid <= 1'b1;
                skid_valid  <= in_take;
            end else if (in_take && stage_free) begin
                stage_valid <= 1'b1;
            end else if (in_take && !skid_valid) begin
                skid_valid <= 1'b1;
            end else if (stage_valid && queue_allowin) begin
                stage_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush || serializing) begin
            stage_pkt <= pkt_empty;
            skid_pkt  <= pkt_empty;
        end else if (skid_valid && stage_free) begin
            stage_pkt <= skid_pkt;
            if (in_take) begin
                skid_pkt <= in_pkt;
            end
        end else if (in_take && stage_free) begin
            stage_pkt <= in_pkt;
        end else if (in_take && !skid_valid) begin
            // response in flight while stage is stuck
            skid_pkt <= in_pkt;
        end
    end

endmodule

//--- if1/if1_serialize.sv
`timescale 1ns/1ps

module if1_serialize import if1_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  logic [1:0]  ibar_flag,
    input  logic [1:0]  csr_flag,
    input  logic [1:0]  tlb_flag,
    input  logic [1:0]  priv_flag,
    input  logic [31:0] pc_out,
    input  logic        ibar_from_ex,
    input  logic        csr_from_ex,
    input  logic        tlb_from_ex,
    input  logic        icache_idle,
    input  logic        dcache_idle,
    input  logic        csr_done,
    input  logic        tlb_done,
    output logic        serializing,
    output logic        flush_req,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    ser_state_t  state;
    ser_state_t  state_nxt;
    logic [31:0] pc_after_priv;
    logic        start;

    // restart point after the flagged instruction
    always_comb begin
        if (priv_flag[0]) begin
            pc_after_priv = pc_out + 32'd4;
        end else if (priv_flag[1]) begin
            pc_after_priv = pc_out + 32'd8;
        end else begin
            pc_after_priv = 32'h0;
        end
    end

    assign start = (state == ser_idle) && (|ibar_flag || |csr_flag || |tlb_flag);

    always_comb begin
        state_nxt = state;
        case (state)
            ser_idle: begin
                // barrier wins over csr, csr over tlb
                if (|ibar_flag) begin
                    state_nxt = ser_wait_ex_ibar;
                end else if (|csr_flag) begin
                    state_nxt = ser_wait_ex_csr;
                end else if (|tlb_flag) begin
                    state_nxt = ser_wait_ex_tlb;
                end
            end
            ser_wait_ex_ibar:    if (ibar_from_ex) state_nxt = ser_wait_cache_idle;
            ser_wait_ex_csr:     if (csr_from_ex) state_nxt = ser_wait_csr_done;
            ser_wait_ex_tlb:     if (tlb_from_ex) state_nxt = ser_wait_tlb_done;
            ser_wait_cache_idle: if (icache_idle && dcache_idle) state_nxt = ser_idle;
            ser_wait_csr_done:   if (csr_done) state_nxt = ser_idle;
            ser_wait_tlb_done:   if (tlb_done) state_nxt = ser_idle;
            default:             state_nxt = ser_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            state <= ser_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // captured once, held for the whole sequence
    always_ff @(posedge clk) begin
        if (start) begin
            redirect_pc <= pc_after_priv;
        end
    end

    assign serializing    = (state != ser_idle);
    assign redirect_valid = serializing;
    assign flush_req      = (state == ser_wait_ex_ibar) || (state == ser_wait_ex_csr) ||
                            (state == ser_wait_ex_tlb);

endmodule

//--- source/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue import if1_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic       flush,
    input  logic       stage_valid,
    input  fetch_pkt_t stage_pkt,
    output logic       queue_allowin,
    output logic       deq_valid,
    input  logic       deq_ready,
    output fetch_pkt_t deq_pkt
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    fetch_pkt_t       mem [QUEUE_DEPTH];
    // extra top bit tells full from empty
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic [PTR_W-1:0] wr_idx;
    logic [PTR_W-1:0] rd_idx;
    logic             full;
    logic             empty;
    logic             do_write;
    logic             do_read;

    assign wr_idx = wr_ptr[PTR_W-1:0];
    assign rd_idx = rd_ptr[PTR_W-1:0];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) && (wr_idx == rd_idx);

    assign queue_allowin = !full;
    assign deq_valid     = !empty;
    assign deq_pkt       = mem[rd_idx];

    assign do_write = stage_valid && queue_allowin;
    assign do_read  = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_idx] <= stage_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- source/if1_top.sv
`timescale 1ns/1ps

module if1_top import if1_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rstn,
    // instruction cache
    input  logic        icache_rvalid,
    output logic        icache_ready,
    input  logic [31:0] pc_out,
    input  logic [31:0] pc_next,
    input  logic [31:0] inst0,
    input  logic [31:0] inst1,
    input  logic [31:0] badv,
    input  logic [6:0]  excp_code,
    input  logic [1:0]  excp_flag,
    // pre-decoder
    input  logic [1:0]  ibar_flag,
    input  logic [1:0]  csr_flag,
    input  logic [1:0]  tlb_flag,
    input  logic [1:0]  priv_flag,
    // execute and memory
    input  logic        ibar_from_ex,
    input  logic        csr_from_ex,
    input  logic        tlb_from_ex,
    input  logic        icache_idle,
    input  logic        dcache_idle,
    input  logic        csr_done,
    input  logic        tlb_done,
    input  logic        flush,
    output logic        flush_req,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    // decoder
    output logic        deq_valid,
    input  logic        deq_ready,
    output logic [31:0] deq_pc,
    output logic [31:0] deq_pc_next,
    output logic [31:0] deq_inst0,
    output logic [31:0] deq_inst1,
    output logic [31:0] deq_badv,
    output logic [6:0]  deq_excp_code,
    output logic [1:0]  deq_excp_flag
);

    logic       serializing;
    logic       stage_valid;
    logic       queue_allowin;
    fetch_pkt_t stage_pkt;
    fetch_pkt_t deq_pkt;

    if1_align u_align (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .serializing   (serializing),
        .icache_rvalid (icache_rvalid),
        .pc_out        (pc_out),
        .pc_next       (pc_next),
        .inst0         (inst0),
        .inst1         (inst1),
        .badv          (badv),
        .excp_code     (excp_code),
        .excp_flag     (excp_flag),
        .priv_flag     (priv_flag),
        .icache_ready  (icache_ready),
        .queue_allowin (queue_allowin),
        .stage_valid   (stage_valid),
        .stage_pkt     (stage_pkt)
    );

    if1_serialize u_serialize (
        .clk            (clk),
        .rstn           (rstn),
        .flush          (flush),
        .ibar_flag      (ibar_flag),
        .csr_flag       (csr_flag),
        .tlb_flag       (tlb_flag),
        .priv_flag      (priv_flag),
        .pc_out         (pc_out),
        .ibar_from_ex   (ibar_from_ex),
        .csr_from_ex    (csr_from_ex),
        .tlb_from_ex    (tlb_from_ex),
        .icache_idle    (icache_idle),
        .dcache_idle    (dcache_idle),
        .csr_done       (csr_done),
        .tlb_done       (tlb_done),
        .serializing    (serializing),
        .flush_req      (flush_req),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .stage_valid   (stage_valid),
        .stage_pkt     (stage_pkt),
        .queue_allowin (queue_allowin),
        .deq_valid     (deq_valid),
        .deq_ready     (deq_ready),
        .deq_pkt       (deq_pkt)
    );

    // head packet out to the decoder as separate fields
    assign deq_pc        = deq_pkt.pc;
    assign deq_pc_next   = deq_pkt.pc_next;
    assign deq_inst0     = deq_pkt.inst0;
    assign deq_inst1     = deq_pkt.inst1;
    assign deq_badv      = deq_pkt.badv;
    assign deq_excp_code = deq_pkt.excp_code;
    assign deq_excp_flag = deq_pkt.excp_flag;

endmodule

//--- bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset seen low by the first RESET_CYCLES rising edges
    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

//--- bench/tb_if1.sv
`timescale 1ns/1ps

module tb_if1 import if1_pkg::*; ();

    localparam int    QUEUE_DEPTH  = 4;
    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 8;
    localparam string STIM_FILE    = "bench/if1_stimulus.txt";

    logic        clk;
    logic        rstn;
    logic        icache_rvalid;
    logic        icache_ready;
    logic [31:0] pc_out;
    logic [31:0] pc_next;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [31:0] badv;
    logic [6:0]  excp_code;
    logic [1:0]  excp_flag;
    logic [1:0]  ibar_flag;
    logic [1:0]  csr_flag;
    logic [1:0]  tlb_flag;
    logic [1:0]  priv_flag;
    logic        ibar_from_ex;
    logic        csr_from_ex;
    logic        tlb_from_ex;
    logic        icache_idle;
    logic        dcache_idle;
    logic        csr_done;
    logic        tlb_done;
    logic        flush;
    logic        flush_req;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        deq_valid;
    logic        deq_ready = 1'b0;
    logic [31:0] deq_pc;
    logic [31:0] deq_pc_next;
    logic [31:0] deq_inst0;
    logic [31:0] deq_inst1;
    logic [31:0] deq_badv;
    logic [6:0]  deq_excp_code;
    logic [1:0]  deq_excp_flag;

    // packets still owed by the DUT, oldest first
    fetch_pkt_t  exp_q[$];
    logic        ready_random = 1'b0;
    logic [31:0] lcg_state = 32'd50;
    int          n_lines = 0;

    tb_clkgen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clkgen (
        .clk  (clk),
        .rstn (rstn)
    );

    if1_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (.*);

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_redirect(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR redirect_pc got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR deq_pkt got 0x%h expected 0x%h", got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // decoder side, random stalls
    always @(posedge clk) begin
        lcg_state = lcg_next(lcg_state);
        deq_ready <= ready_random && lcg_state[16];
    end

    always @(negedge clk) begin : deq_monitor
        fetch_pkt_t got;
        got = {deq_pc, deq_pc_next, deq_inst0, deq_inst1, deq_badv, deq_excp_code,
               deq_excp_flag};
        if (rstn && deq_valid && deq_ready) begin
            if (exp_q.size() == 0) begin
                abort_run("a packet left the queue while no packet was expected");
            end else begin
                check_pkt(got, exp_q.pop_front());
            end
        end
    end

    // one response, only after icache_ready was seen high in the cycle before
    task automatic send_response(input fetch_pkt_t raw, input logic [1:0] priv);
        @(negedge clk);
        while (!icache_ready) begin
            @(posedge clk);
            icache_rvalid <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        icache_rvalid <= 1'b1;
        pc_out        <= raw.pc;
        pc_next       <= raw.pc_next;
        inst0         <= raw.inst0;
        inst1         <= raw.inst1;
        badv          <= raw.badv;
        excp_code     <= raw.excp_code;
        excp_flag     <= raw.excp_flag;
        priv_flag     <= priv;
    endtask

    task automatic bus_idle();
        @(posedge clk);
        icache_rvalid <= 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (exp_q.size() != 0 || deq_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic set_ready_mode(input logic mode);
        bus_idle();
        wait_drained();
        ready_random = mode;
    endtask

    // fetch must stay stopped while the controller holds it
    task automatic check_held(input logic exp_flush_req, input logic [31:0] exp_pc);
        check_bit("redirect_valid", redirect_valid, 1'b1);
        check_bit("flush_req", flush_req, exp_flush_req);
        check_bit("icache_ready", icache_ready, 1'b0);
        check_bit("deq_valid", deq_valid, 1'b0);
        check_redirect(redirect_pc, exp_pc);
    endtask

    task automatic run_serialize(input logic [3:0] kind, input logic [1:0] priv,
                                 input logic [31:0] pc, input logic [31:0] exp_pc,
                                 input logic [7:0] ex_wait, input logic [7:0] done_wait);
        bus_idle();
        wait_drained();
        @(posedge clk);
        pc_out    <= pc;
        priv_flag <= priv;
        ibar_flag <= (kind == 4'd1) ? 2'b01 : 2'b00;
        csr_flag  <= (kind == 4'd2) ? 2'b01 : 2'b00;
        tlb_flag  <= (kind == 4'd3) ? 2'b01 : 2'b00;
        @(posedge clk);
        ibar_flag <= 2'b00;
        csr_flag  <= 2'b00;
        tlb_flag  <= 2'b00;
        // response still in flight as fetch stops, it must be refused
        icache_rvalid <= 1'b1;
        @(negedge clk);
        check_held(1'b1, exp_pc);
        @(posedge clk);
        icache_rvalid <= 1'b0;
        repeat (ex_wait) begin
            @(negedge clk);
            check_held(1'b1, exp_pc);
        end
        @(posedge clk);
        ibar_from_ex <= (kind == 4'd1);
        csr_from_ex  <= (kind == 4'd2);
        tlb_from_ex  <= (kind == 4'd3);
        @(posedge clk);
        ibar_from_ex <= 1'b0;
        csr_from_ex  <= 1'b0;
        tlb_from_ex  <= 1'b0;
        // icache idle alone must not release a barrier
        icache_idle  <= (kind == 4'd1);
        @(negedge clk);
        check_held(1'b0, exp_pc);
        repeat (done_wait) begin
            @(negedge clk);
            check_held(1'b0, exp_pc);
        end
        @(posedge clk);
        dcache_idle <= (kind == 4'd1);
        csr_done    <= (kind == 4'd2);
        tlb_done    <= (kind == 4'd3);
        @(posedge clk);
        icache_idle <= 1'b0;
        dcache_idle <= 1'b0;
        csr_done    <= 1'b0;
        tlb_done    <= 1'b0;
        @(negedge clk);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_bit("flush_req", flush_req, 1'b0);
        check_bit("icache_ready", icache_ready, 1'b1);
    endtask

    task automatic do_flush();
        bus_idle();
        // a barrier in progress is dropped by the flush as well
        ibar_flag <= 2'b01;
        @(posedge clk);
        ibar_flag <= 2'b00;
        flush     <= 1'b1;
        @(negedge clk);
        check_bit("redirect_valid", redirect_valid, 1'b1);
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_bit("deq_valid", deq_valid, 1'b0);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_bit("flush_req", flush_req, 1'b0);
    endtask

    initial begin : stimulus
        int               fd;
        int               rc;
        logic [8*160-1:0] text;
        logic [7:0]       cmd;
        logic             done;
        logic [31:0]      f_pc;
        logic [31:0]      f_pc_next;
        logic [31:0]      f_inst0;
        logic [31:0]      f_inst1;
        logic [31:0]      f_badv;
        logic [6:0]       f_code;
        logic [1:0]       f_flag;
        logic [1:0]       f_priv;
        logic [3:0]       s_kind;
        logic [7:0]       s_ex;
        logic [7:0]       s_done;
        logic             s_mode;

        icache_rvalid = 1'b0;
        pc_out        = 32'h0;
        pc_next       = 32'h0;
        inst0         = 32'h0;
        inst1         = 32'h0;
        badv          = 32'h0;
        excp_code     = 7'h0;
        excp_flag     = 2'b00;
        ibar_flag     = 2'b00;
        csr_flag      = 2'b00;
        tlb_flag      = 2'b00;
        priv_flag     = 2'b00;
        ibar_from_ex  = 1'b0;
        csr_from_ex   = 1'b0;
        tlb_from_ex   = 1'b0;
        icache_idle   = 1'b0;
        dcache_idle   = 1'b0;
        csr_done      = 1'b0;
        tlb_done      = 1'b0;
        flush         = 1'b0;

        // line count sizes the watchdog
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end
        while (!$feof(fd)) begin
            rc = $fgets(text, fd);
            if (rc > 0) begin
                n_lines++;
            end
        end
        $fclose(fd);
        fd = $fopen(STIM_FILE, "r");

        @(negedge clk);
        check_bit("icache_ready", icache_ready, 1'b0);
        check_bit("deq_valid", deq_valid, 1'b0);
        check_bit("redirect_valid", redirect_valid, 1'b0);
        check_bit("flush_req", flush_req, 1'b0);
        wait (rstn === 1'b1);
        // stage not yet known empty
        @(negedge clk);
        check_bit("icache_ready", icache_ready, 1'b0);

        done = 1'b0;
        while (!done) begin
            rc = $fscanf(fd, "%s", cmd);
            if (rc != 1) begin
                done = 1'b1;
            end else begin
                case (cmd)
                    "#": rc = $fgets(text, fd);
                    "R": begin
                        rc = $fscanf(fd, "%h %h %h %h %h %h %h %h", f_pc, f_pc_next,
                                     f_inst0, f_inst1, f_badv, f_code, f_flag, f_priv);
                        if (rc != 8) begin
                            abort_run("a response line in the stimulus file is malformed");
                        end
                        send_response({f_pc, f_pc_next, f_inst0, f_inst1, f_badv, f_code,
                                       f_flag}, f_priv);
                    end
                    "E": begin
                        rc = $fscanf(fd, "%h %h %h %h %h %h %h", f_pc, f_pc_next,
                                     f_inst0, f_inst1, f_badv, f_code, f_flag);
                        if (rc != 7) begin
                            abort_run("an expected packet line is malformed");
                        end
                        exp_q.push_back({f_pc, f_pc_next, f_inst0, f_inst1, f_badv, f_code,
                                         f_flag});
                    end
                    "S": begin
                        rc = $fscanf(fd, "%h %h %h %h %h %h", s_kind, f_priv, f_pc,
                                     f_badv, s_ex, s_done);
                        if (rc != 6) begin
                            abort_run("a serialization line is malformed");
                        end
                        run_serialize(s_kind, f_priv, f_pc, f_badv, s_ex, s_done);
                    end
                    "M": begin
                        rc = $fscanf(fd, "%h", s_mode);
                        set_ready_mode(s_mode);
                    end
                    "F": do_flush();
                    default: abort_run("unknown command in the stimulus file");
                endcase
            end
        end
        $fclose(fd);

        bus_idle();
        wait_drained();
        repeat (2) @(negedge clk);
        $display("All tests passed");
        $finish;
    end

    initial begin : watchdog
        wait (n_lines > 0);
        #((n_lines * 20 + RESET_CYCLES) * CLK_PERIOD);
        abort_run("timeout, the stimulus did not complete in the allowed time");
    end

endmodule

//--- bench/if1_stimulus.txt
# R pc pc_next inst0 inst1 badv excp_code excp_flag priv_flag / E pc pc_next inst0 inst1 badv excp_code excp_flag
# S kind(1 ibar 2 csr 3 tlb) priv_flag pc redirect_pc ex_wait done_wait / M deq_ready_random / F flush
M 1
R 1c000000 1c000008 02800401 02800802 00000000 00 0 0
E 1c000000 1c000008 02800401 02800802 00000000 00 0
R 1c000008 1c000010 02800c03 02801004 00000000 00 0 0
E 1c000008 1c000010 02800c03 02801004 00000000 00 0
R 1c000014 1c000018 02801405 02801806 00000000 00 0 0
E 1c000014 1c000018 02801806 03400000 00000000 00 0
R 1c000018 1c000020 02801c07 02802008 1c000018 08 1 0
E 1c000018 1c000020 02801c07 02802008 1c000018 08 1
R 1c000020 1c000028 04000009 0400000a 1c000020 08 2 1
E 1c000020 1c000028 04000009 0400000a 1c000020 08 0
R 1c00002c 1c000030 0280300b 0280340c 00000000 00 0 0
E 1c00002c 1c000030 0280340c 03400000 00000000 00 0
R 1c000030 1c000038 0280380d 02803c0e 1c000034 03 3 2
E 1c000030 1c000038 0280380d 02803c0e 1c000034 03 3
R 1c000038 1c000040 0280400f 02804410 00000000 00 0 0
E 1c000038 1c000040 0280400f 02804410 00000000 00 0
S 1 1 1c000040 1c000044 3 2
S 2 2 1c000050 1c000058 2 3
S 3 0 1c000060 00000000 1 1
M 0
R a0000000 a0000008 deadbeef deadbeef 00000000 00 0 0
R a0000008 a0000010 deadbeef deadbeef 00000000 00 0 0
R a0000010 a0000018 deadbeef deadbeef 00000000 00 0 0
F
M 1
R 1c000080 1c000088 02808011 02808412 00000000 00 0 0
E 1c000080 1c000088 02808011 02808412 00000000 00 0
R 1c00008c 1c000090 02808813 02808c14 00000000 00 0 0
E 1c00008c 1c000090 02808c14 03400000 00000000 00 0
R 1c000090 1c000098 02809015 02809416 1c000090 0a 1 0
E 1c000090 1c000098 02809015 02809416 1c000090 0a 1

//--- if1.f
common/if1_pkg.sv
if1/if1_align.sv
if1/if1_serialize.sv
source/fetch_queue.sv
source/if1_top.sv
bench/tb_clkgen.sv
bench/tb_if1.sv

//--- run_if1.sh
#!/bin/sh
# compile with Verilator, run, then decide from the log
rm -f sim_if1.log && \
verilator --binary --timing --timescale 1ns/1ps -f if1.f --top-module tb_if1 \
    -o tb_if1_sim && \
./obj_dir/tb_if1_sim > sim_if1.log 2>&1 || \
echo "build or simulation returned an error"
grep -q "All tests passed" sim_if1.log && echo "PASS" || { echo "FAIL"; exit 1; }
